/* hdl/ice_bus_pkg.sv */
`default_nettype none

package ice_bus_pkg;

	// One character of the debug link
	typedef logic [7:0] char_t;

	// Master bus driven by the frame receiver
	typedef struct packed {
		logic  frame_valid;
		logic  data_valid;
		char_t addr;
		char_t data;
	} ma_bus_t;

	// Response buffer entry, last marks the final byte of a message
	typedef struct packed {
		logic  last;
		char_t data;
	} sl_word_t;

	typedef enum logic [2:0] {
		RX_IDLE,
		RX_ID,
		RX_LEN,
		RX_PAYLOAD,
		RX_DISCARD,
		RX_NAK
	} rx_state_t;

	typedef enum logic [2:0] {
		TX_IDLE,
		TX_GETLEN,
		TX_HEADER,
		TX_LEN,
		TX_PAYLOAD,
		TX_RELEASE
	} tx_state_t;

endpackage

`default_nettype wire

/* hdl/frame_receiver.sv */
`timescale 1ns/1ns
`default_nettype none

module frame_receiver
	import ice_bus_pkg::*;
(
	input  logic    clk,
	input  logic    rst,
	input  char_t   rx_char,
	input  logic    rx_char_valid,
	output ma_bus_t ma_bus,
	input  logic    sl_overflow,
	output logic    generate_nak,
	output char_t   evt_id
);

	rx_state_t state, state_nxt;
	char_t addr_q;
	char_t len_q;
	char_t pay_cnt;
	logic  capture_addr;
	logic  capture_id;
	logic  capture_len;
	logic  count_byte;
	logic  last_byte;

	// Current payload character is the final one of the frame
	assign last_byte = (pay_cnt + 8'd1) == len_q;

	always_comb begin
		state_nxt = state;
		capture_addr = 1'b0;
		capture_id = 1'b0;
		capture_len = 1'b0;
		count_byte = 1'b0;
		ma_bus.frame_valid = 1'b0;
		ma_bus.data_valid = 1'b0;
		ma_bus.addr = addr_q;
		ma_bus.data = rx_char;

		case (state)
			// A new frame may start right in the NAK cycle
			RX_IDLE, RX_NAK: begin
				state_nxt = RX_IDLE;
				if (rx_char_valid) begin
					ma_bus.frame_valid = 1'b1;
					capture_addr = 1'b1;
					state_nxt = RX_ID;
				end
			end
			RX_ID: begin
				ma_bus.frame_valid = 1'b1;
				if (rx_char_valid) begin
					ma_bus.data_valid = 1'b1;
					capture_id = 1'b1;
					state_nxt = RX_LEN;
				end
			end
			RX_LEN: begin
				ma_bus.frame_valid = 1'b1;
				if (rx_char_valid) begin
					ma_bus.data_valid = 1'b1;
					capture_len = 1'b1;
					state_nxt = (rx_char == 8'd0) ? RX_IDLE : RX_PAYLOAD;
				end
			end
			RX_PAYLOAD: begin
				count_byte = rx_char_valid;
				if (sl_overflow) begin
					// Character seen with overflow is dropped too
					state_nxt = (rx_char_valid && last_byte) ? RX_NAK : RX_DISCARD;
				end else begin
					ma_bus.frame_valid = 1'b1;
					ma_bus.data_valid = rx_char_valid;
					if (rx_char_valid && last_byte)
						state_nxt = RX_IDLE;
				end
			end
			RX_DISCARD: begin
				count_byte = rx_char_valid;
				if (rx_char_valid && last_byte)
					state_nxt = RX_NAK;
			end
			default: state_nxt = RX_IDLE;
		endcase
	end

	assign generate_nak = (state == RX_NAK);

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= RX_IDLE;
			pay_cnt <= '0;
		end else begin
			state <= state_nxt;
			if (capture_len)
				pay_cnt <= '0;
			else if (count_byte)
				pay_cnt <= pay_cnt + 8'd1;
		end
	end

	// Frame header fields
	always_ff @(posedge clk) begin
		if (capture_addr)
			addr_q <= rx_char;
		if (capture_id)
			evt_id <= rx_char;
		if (capture_len)
			len_q <= rx_char;
	end

endmodule

`default_nettype wire

/* hdl/response_buffer.sv */
`timescale 1ns/1ns
`default_nettype none

module response_buffer
	import ice_bus_pkg::*;
#(
	parameter int BUF_ADDR_W = 6
) (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  wr_valid,
	input  sl_word_t              wr_word,
	output logic                  wr_ready,
	output logic                  msg_pending,
	input  logic [BUF_ADDR_W-1:0] rd_offset,
	output sl_word_t              rd_word,
	input  logic                  release_msg,
	input  logic [BUF_ADDR_W:0]   release_len
);

	localparam int DEPTH = 2 ** BUF_ADDR_W;

	sl_word_t mem [DEPTH];

	logic [BUF_ADDR_W-1:0] head;
	logic [BUF_ADDR_W-1:0] tail;
	logic [BUF_ADDR_W-1:0] rd_addr;
	logic [BUF_ADDR_W:0]   fill_cnt;
	logic [BUF_ADDR_W:0]   msg_cnt;
	logic [BUF_ADDR_W:0]   fill_inc;
	logic [BUF_ADDR_W:0]   fill_dec;
	logic [BUF_ADDR_W:0]   msg_inc;
	logic [BUF_ADDR_W:0]   msg_dec;
	logic                  wr_en;

	// Full when every entry holds an unreleased word
	assign wr_ready = fill_cnt != (BUF_ADDR_W+1)'(DEPTH);
	assign wr_en = wr_valid && wr_ready;

	// Reads are relative to the oldest unreleased word
	assign rd_addr = tail + rd_offset;
	assign rd_word = mem[rd_addr];

	assign msg_pending = msg_cnt != '0;

	assign fill_inc = (BUF_ADDR_W+1)'(wr_en);
	assign fill_dec = release_msg ? release_len : '0;

	// Completed messages rise on the last byte and fall on release
	assign msg_inc = (BUF_ADDR_W+1)'(wr_en && wr_word.last);
	assign msg_dec = (BUF_ADDR_W+1)'(release_msg);

	always_ff @(posedge clk) begin
		if (wr_en)
			mem[head] <= wr_word;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			head <= '0;
			tail <= '0;
			fill_cnt <= '0;
			msg_cnt <= '0;
		end else begin
			if (wr_en)
				head <= head + 1'b1;
			// A full-depth release wraps the tail onto itself
			if (release_msg)
				tail <= tail + release_len[BUF_ADDR_W-1:0];
			fill_cnt <= fill_cnt + fill_inc - fill_dec;
			msg_cnt <= msg_cnt + msg_inc - msg_dec;
		end
	end

endmodule

`default_nettype wire

/* hdl/priority_select.sv */
`timescale 1ns/1ns
`default_nettype none

module priority_select #(
	parameter int NUM_DEV = 2
) (
	input  logic               clk,
	input  logic               rst,
	input  logic [NUM_DEV-1:0] requests,
	input  logic               hold,
	output logic [NUM_DEV-1:0] grants,
	output logic               granted
);

	logic [NUM_DEV-1:0] pick;

	// Lowest index wins
	always_comb begin
		pick = '0;
		for (int i = 0; i < NUM_DEV; i++) begin
			if (requests[i] && pick == '0)
				pick[i] = 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (rst)
			grants <= '0;
		else if (!hold)
			grants <= pick;
	end

	assign granted = |grants;

endmodule

`default_nettype wire

/* hdl/frame_transmitter.sv */
`timescale 1ns/1ns
`default_nettype none

module frame_transmitter
	import ice_bus_pkg::*;
#(
	parameter int NUM_DEV    = 2,
	parameter int BUF_ADDR_W = 6
) (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  granted,
	input  logic [NUM_DEV-1:0]    grants,
	input  sl_word_t              rd_words [NUM_DEV],
	output logic [BUF_ADDR_W-1:0] rd_offset,
	output logic                  hold,
	output logic [NUM_DEV-1:0]    release_msg,
	output logic [BUF_ADDR_W:0]   release_len,
	output char_t                 tx_char,
	output logic                  tx_char_valid,
	input  logic                  tx_char_ready
);

	localparam int IDX_W = (NUM_DEV > 1) ? $clog2(NUM_DEV) : 1;

	tx_state_t state, state_nxt;
	logic [IDX_W-1:0]      grant_idx;
	sl_word_t              cur_word;
	logic [BUF_ADDR_W-1:0] offset;
	logic [BUF_ADDR_W:0]   msg_len;
	char_t                 len_char;
	logic                  offset_clr;
	logic                  offset_inc;
	logic                  save_len;
	logic                  grant_fresh;

	always_comb begin
		grant_idx = '0;
		for (int i = 0; i < NUM_DEV; i++) begin
			if (grants[i])
				grant_idx = IDX_W'(i);
		end
	end

	assign cur_word = rd_words[grant_idx];
	assign rd_offset = offset;
	assign release_len = msg_len;
	assign hold = (state != TX_IDLE);

	// Length character excludes address and event id
	assign len_char = char_t'(msg_len - (BUF_ADDR_W+1)'(2));

	always_comb begin
		state_nxt = state;
		offset_clr = 1'b0;
		offset_inc = 1'b0;
		save_len = 1'b0;
		tx_char_valid = 1'b0;
		tx_char = cur_word.data;
		release_msg = '0;

		case (state)
			TX_IDLE: begin
				offset_clr = 1'b1;
				// Grant must be sampled after the last release took effect
				if (granted && grant_fresh)
					state_nxt = TX_GETLEN;
			end
			TX_GETLEN: begin
				if (cur_word.last) begin
					save_len = 1'b1;
					offset_clr = 1'b1;
					state_nxt = TX_HEADER;
				end else begin
					offset_inc = 1'b1;
				end
			end
			TX_HEADER: begin
				tx_char_valid = 1'b1;
				if (tx_char_ready) begin
					offset_inc = 1'b1;
					if (offset == BUF_ADDR_W'(1))
						state_nxt = TX_LEN;
				end
			end
			TX_LEN: begin
				tx_char_valid = 1'b1;
				tx_char = len_char;
				if (tx_char_ready)
					state_nxt = (msg_len == (BUF_ADDR_W+1)'(2)) ? TX_RELEASE : TX_PAYLOAD;
			end
			TX_PAYLOAD: begin
				tx_char_valid = 1'b1;
				if (tx_char_ready) begin
					offset_inc = 1'b1;
					if (cur_word.last)
						state_nxt = TX_RELEASE;
				end
			end
			TX_RELEASE: begin
				release_msg = grants;
				state_nxt = TX_IDLE;
			end
			default: state_nxt = TX_IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= TX_IDLE;
			offset <= '0;
			grant_fresh <= 1'b0;
		end else begin
			state <= state_nxt;
			grant_fresh <= (state == TX_IDLE);
			if (offset_clr)
				offset <= '0;
			else if (offset_inc)
				offset <= offset + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (save_len)
			msg_len <= (BUF_ADDR_W+1)'(offset) + (BUF_ADDR_W+1)'(1);
	end

endmodule

`default_nettype wire

/* hdl/ice_bus_controller.sv */
`timescale 1ns/1ns
`default_nettype none

module ice_bus_controller
	import ice_bus_pkg::*;
#(
	parameter int NUM_DEV    = 2,
	parameter int BUF_ADDR_W = 6
) (
	input  logic               clk,
	input  logic               rst,
	input  char_t              rx_char,
	input  logic               rx_char_valid,
	output char_t              tx_char,
	output logic               tx_char_valid,
	input  logic               tx_char_ready,
	output ma_bus_t            ma_bus,
	input  logic               sl_overflow,
	output logic               generate_nak,
	output char_t              evt_id,
	input  logic [NUM_DEV-1:0] wr_valid,
	input  sl_word_t           wr_word [NUM_DEV],
	output logic [NUM_DEV-1:0] wr_ready
);

	logic [NUM_DEV-1:0]    msg_pending;
	logic [NUM_DEV-1:0]    grants;
	logic [NUM_DEV-1:0]    msg_release;
	logic                  granted;
	logic                  hold;
	logic [BUF_ADDR_W-1:0] rd_offset;
	logic [BUF_ADDR_W:0]   release_len;
	sl_word_t              rd_words [NUM_DEV];

	// Host to master bus path
	frame_receiver u_rx (
		.clk           (clk),
		.rst           (rst),
		.rx_char       (rx_char),
		.rx_char_valid (rx_char_valid),
		.ma_bus        (ma_bus),
		.sl_overflow   (sl_overflow),
		.generate_nak  (generate_nak),
		.evt_id        (evt_id)
	);

	// One response buffer per device, sharing the relative read offset
	for (genvar d = 0; d < NUM_DEV; d++) begin : g_buf
		response_buffer #(
			.BUF_ADDR_W (BUF_ADDR_W)
		) u_buf (
			.clk         (clk),
			.rst         (rst),
			.wr_valid    (wr_valid[d]),
			.wr_word     (wr_word[d]),
			.wr_ready    (wr_ready[d]),
			.msg_pending (msg_pending[d]),
			.rd_offset   (rd_offset),
			.rd_word     (rd_words[d]),
			.release_msg (msg_release[d]),
			.release_len (release_len)
		);
	end

	priority_select #(
		.NUM_DEV (NUM_DEV)
	) u_arb (
		.clk      (clk),
		.rst      (rst),
		.requests (msg_pending),
		.hold     (hold),
		.grants   (grants),
		.granted  (granted)
	);

	frame_transmitter #(
		.NUM_DEV    (NUM_DEV),
		.BUF_ADDR_W (BUF_ADDR_W)
	) u_tx (
		.clk           (clk),
		.rst           (rst),
		.granted       (granted),
		.grants        (grants),
		.rd_words      (rd_words),
		.rd_offset     (rd_offset),
		.hold          (hold),
		.release_msg   (msg_release),
		.release_len   (release_len),
		.tx_char       (tx_char),
		.tx_char_valid (tx_char_valid),
		.tx_char_ready (tx_char_ready)
	);

endmodule

`default_nettype wire

/* testbench/tb_clock.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_clock (
	output logic clk,
	output logic rst
);

	initial clk = 1'b0;
	always #50 clk = ~clk;

	// Reset spans three rising edges
	initial begin
		rst = 1'b1;
		repeat (3) @(posedge clk);
		rst <= 1'b0;
	end

endmodule

`default_nettype wire

/* testbench/tb_checker.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_checker
	import ice_bus_pkg::*;
(
	input logic    clk,
	input logic    rst,
	input ma_bus_t ma_bus,
	input logic    generate_nak,
	input char_t   evt_id,
	input logic    rx_char_valid,
	input char_t   tx_char,
	input logic    tx_char_valid,
	input logic    tx_char_ready
);

	char_t exp_data_q [$];
	char_t exp_addr_q [$];
	int    exp_cnt_q [$];
	char_t exp_nak_q [$];
	char_t exp_tx_q [$];
	int    bus_errs = 0;
	int    nak_errs = 0;
	int    tx_errs = 0;
	int    buf_errs = 0;
	int    dv_cnt;
	int    exp_n;
	char_t exp_c;
	logic  prev_fv, prev_dv, prev_rxv, prev_txv, prev_txr;
	char_t prev_txc;

	task expect_frame(input char_t addr, input int cnt);
		exp_addr_q.push_back(addr);
		exp_cnt_q.push_back(cnt);
	endtask

	task expect_data(input char_t c);
		exp_data_q.push_back(c);
	endtask

	task expect_nak(input char_t id);
		exp_nak_q.push_back(id);
	endtask

	task expect_tx(input char_t c);
		exp_tx_q.push_back(c);
	endtask

	function automatic int tx_left();
		return exp_tx_q.size();
	endfunction

	task check_ready(input int dev, input logic got, input logic exp);
		if (got !== exp) begin
			$display("[ERROR] wr_ready[%0d]: got %h expected %h", dev, got, exp);
			buf_errs++;
		end
	endtask

	task final_check();
		if (exp_data_q.size() != 0 || exp_cnt_q.size() != 0) begin
			$display("Master bus characters were expected but never appeared");
			bus_errs++;
		end
		if (exp_nak_q.size() != 0) begin
			$display("A NAK pulse was expected but never appeared");
			nak_errs++;
		end
		if (exp_tx_q.size() != 0) begin
			$display("%0d tx characters were expected but never sent", exp_tx_q.size());
			tx_errs++;
		end
	endtask

	// Everything is sampled mid-cycle, away from the driving edge
	always @(negedge clk) begin
		if (rst) begin
			dv_cnt = 0;
			{prev_fv, prev_dv, prev_rxv, prev_txv, prev_txr} = '0;
			prev_txc = '0;
		end else begin
			if (ma_bus.data_valid) begin
				dv_cnt++;
				if (exp_data_q.size() == 0) begin
					$display("Unexpected data_valid pulse on the master bus");
					bus_errs++;
				end else begin
					exp_c = exp_data_q.pop_front();
					if (ma_bus.data !== exp_c) begin
						$display("[ERROR] ma_bus.data: got %h expected %h", ma_bus.data, exp_c);
						bus_errs++;
					end
				end
				if (exp_addr_q.size() != 0 && ma_bus.addr !== exp_addr_q[0]) begin
					$display("[ERROR] ma_bus.addr: got %h expected %h", ma_bus.addr,
						exp_addr_q[0]);
					bus_errs++;
				end
			end
			// End of a frame on the master bus
			if (prev_fv && !ma_bus.frame_valid) begin
				if (exp_cnt_q.size() == 0) begin
					$display("A master bus frame ended where none was expected");
					bus_errs++;
				end else begin
					exp_n = exp_cnt_q.pop_front();
					exp_c = exp_addr_q.pop_front();
					if (dv_cnt != exp_n) begin
						$display("[ERROR] data_valid count: got %h expected %h", dv_cnt, exp_n);
						bus_errs++;
					end
				end
				if (!prev_dv) begin
					$display("frame_valid did not drop right after the last character");
					bus_errs++;
				end
				dv_cnt = 0;
			end
			if (generate_nak) begin
				if (exp_nak_q.size() == 0) begin
					$display("Unexpected generate_nak pulse");
					nak_errs++;
				end else begin
					exp_c = exp_nak_q.pop_front();
					if (evt_id !== exp_c) begin
						$display("[ERROR] evt_id: got %h expected %h", evt_id, exp_c);
						nak_errs++;
					end
				end
				if (!prev_rxv) begin
					$display("generate_nak did not follow the frame's last character");
					nak_errs++;
				end
			end
			// A waiting character must stay put until it is taken
			if (prev_txv && !prev_txr && (!tx_char_valid || tx_char !== prev_txc)) begin
				$display("tx character changed or was withdrawn before its transfer");
				tx_errs++;
			end
			if (tx_char_valid && tx_char_ready) begin
				if (exp_tx_q.size() == 0) begin
					$display("Unexpected character sent on tx");
					tx_errs++;
				end else begin
					exp_c = exp_tx_q.pop_front();
					if (tx_char !== exp_c) begin
						$display("[ERROR] tx_char: got %h expected %h", tx_char, exp_c);
						tx_errs++;
					end
				end
			end
			prev_fv = ma_bus.frame_valid;
			prev_dv = ma_bus.data_valid;
			prev_rxv = rx_char_valid;
			prev_txv = tx_char_valid;
			prev_txr = tx_char_ready;
			prev_txc = tx_char;
		end
	end

endmodule

`default_nettype wire

/* testbench/tb_ice_bus_controller.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_ice_bus_controller
	import ice_bus_pkg::*;
();

	localparam int NUM_DEV = 2;
	localparam int BUF_W = 6;
	localparam int NUM_ROWS = 5;
	localparam int FILL_WORDS = 2 ** BUF_W;

	// One host frame plus one message per device, ovf 0 means no overflow
	typedef struct packed {
		logic [3:0]      n;
		logic [0:7][7:0] frame;
		logic [3:0]      ovf;
		logic [3:0]      l0;
		logic [0:7][7:0] m0;
		logic [3:0]      l1;
		logic [0:7][7:0] m1;
	} row_t;

	logic               clk;
	logic               rst;
	char_t              rx_char;
	logic               rx_char_valid;
	char_t              tx_char;
	logic               tx_char_valid;
	logic               tx_char_ready;
	ma_bus_t            ma_bus;
	logic               sl_overflow;
	logic               generate_nak;
	char_t              evt_id;
	logic [NUM_DEV-1:0] wr_valid;
	sl_word_t           wr_word [NUM_DEV];
	logic [NUM_DEV-1:0] wr_ready;
	row_t               rows [NUM_ROWS];

	tb_clock clkgen (.clk(clk), .rst(rst));

	ice_bus_controller #(
		.NUM_DEV    (NUM_DEV),
		.BUF_ADDR_W (BUF_W)
	) dut (
		.clk           (clk),
		.rst           (rst),
		.rx_char       (rx_char),
		.rx_char_valid (rx_char_valid),
		.tx_char       (tx_char),
		.tx_char_valid (tx_char_valid),
		.tx_char_ready (tx_char_ready),
		.ma_bus        (ma_bus),
		.sl_overflow   (sl_overflow),
		.generate_nak  (generate_nak),
		.evt_id        (evt_id),
		.wr_valid      (wr_valid),
		.wr_word       (wr_word),
		.wr_ready      (wr_ready)
	);

	tb_checker chk (
		.clk           (clk),
		.rst           (rst),
		.ma_bus        (ma_bus),
		.generate_nak  (generate_nak),
		.evt_id        (evt_id),
		.rx_char_valid (rx_char_valid),
		.tx_char       (tx_char),
		.tx_char_valid (tx_char_valid),
		.tx_char_ready (tx_char_ready)
	);

	// Random back-pressure on the tx side
	initial begin
		int unsigned seed_val;
		seed_val = $urandom(32'h12af00ef);
		forever begin
			@(posedge clk);
			tx_char_ready <= ($urandom % 4) != 0;
		end
	end

	task send_frame(input row_t r);
		int cnt;
		cnt = (r.ovf != 0) ? int'(r.ovf) - 1 : int'(r.n) - 1;
		chk.expect_frame(r.frame[0], cnt);
		for (int i = 1; i <= cnt; i++)
			chk.expect_data(r.frame[i]);
		if (r.ovf != 0)
			chk.expect_nak(r.frame[1]);
		for (int i = 0; i < r.n; i++) begin
			@(posedge clk);
			rx_char <= r.frame[i];
			rx_char_valid <= 1'b1;
			sl_overflow <= (r.ovf != 0) && (i == r.ovf);
		end
		@(posedge clk);
		rx_char_valid <= 1'b0;
		sl_overflow <= 1'b0;
		repeat (2) @(posedge clk);
	endtask

	// Header bytes, then length minus the header, then the rest
	task push_message(input int len, input logic [0:7][7:0] m);
		chk.expect_tx(m[0]);
		chk.expect_tx(m[1]);
		chk.expect_tx(char_t'(len - 2));
		for (int i = 2; i < len; i++)
			chk.expect_tx(m[i]);
	endtask

	// Last words of both messages land in the same cycle
	task write_messages(input row_t r);
		int l0, l1, maxl, idx0, idx1;
		l0 = r.l0;
		l1 = r.l1;
		maxl = (l0 > l1) ? l0 : l1;
		if (l0 != 0)
			push_message(l0, r.m0);
		if (l1 != 0)
			push_message(l1, r.m1);
		for (int k = 0; k < maxl; k++) begin
			@(posedge clk);
			idx0 = k - (maxl - l0);
			idx1 = k - (maxl - l1);
			wr_valid <= {idx1 >= 0, idx0 >= 0};
			if (idx0 >= 0)
				wr_word[0] <= '{(idx0 == l0 - 1), r.m0[idx0]};
			if (idx1 >= 0)
				wr_word[1] <= '{(idx1 == l1 - 1), r.m1[idx1]};
		end
		@(posedge clk);
		wr_valid <= '0;
	endtask

	task wait_tx_drain();
		while (chk.tx_left() != 0)
			@(posedge clk);
		// Release follows the last transfer
		repeat (3) @(posedge clk);
	endtask

	// Both buffers take a full depth of words, then refuse one more
	task fill_buffers();
		for (int i = 0; i <= FILL_WORDS; i++) begin
			@(posedge clk);
			wr_valid <= '1;
			wr_word[0] <= '{1'b0, char_t'(i) ^ 8'h5a};
			wr_word[1] <= '{1'b0, char_t'(i) ^ 8'ha5};
			@(negedge clk);
			for (int d = 0; d < NUM_DEV; d++)
				chk.check_ready(d, wr_ready[d], i < FILL_WORDS);
		end
		@(posedge clk);
		wr_valid <= '0;
	endtask

	initial begin
		int total;
		rx_char = '0;
		rx_char_valid = 1'b0;
		tx_char_ready = 1'b0;
		sl_overflow = 1'b0;
		wr_valid = '0;
		wr_word[0] = '0;
		wr_word[1] = '0;
		rows[0] = '{4'd6, 64'hA5_10_03_11_22_33_00_00, 4'd0,
			4'd4, 64'hC1_C2_C3_C4_00_00_00_00, 4'd0, 64'h0};
		rows[1] = '{4'd8, 64'h3C_21_05_01_02_03_04_05, 4'd5,
			4'd0, 64'h0, 4'd3, 64'hD1_D2_D3_00_00_00_00_00};
		rows[2] = '{4'd4, 64'h77_42_01_99_00_00_00_00, 4'd0,
			4'd5, 64'h01_02_03_04_05_00_00_00, 4'd6, 64'hE0_E1_E2_E3_E4_E5_00_00};
		rows[3] = '{4'd5, 64'h5A_43_02_AA_BB_00_00_00, 4'd3,
			4'd2, 64'h0F_1E_00_00_00_00_00_00, 4'd8, 64'h80_81_82_83_84_85_86_87};
		rows[4] = '{4'd5, 64'h12_44_02_66_77_00_00_00, 4'd4,
			4'd7, 64'hA0_A1_A2_A3_A4_A5_A6_00, 4'd7, 64'hB0_B1_B2_B3_B4_B5_B6_00};
		@(negedge rst);
		for (int r = 0; r < NUM_ROWS; r++) begin
			send_frame(rows[r]);
			write_messages(rows[r]);
			wait_tx_drain();
		end
		fill_buffers();
		chk.final_check();
		total = chk.bus_errs + chk.nak_errs + chk.tx_errs + chk.buf_errs;
		$display("Error counts: bus %0d, nak %0d, tx %0d, buffer %0d",
			chk.bus_errs, chk.nak_errs, chk.tx_errs, chk.buf_errs);
		if (total == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

	// Watchdog sized from the characters in the table
	initial begin
		int chars;
		@(posedge clk);
		chars = FILL_WORDS + 1;
		for (int r = 0; r < NUM_ROWS; r++)
			chars += rows[r].n + rows[r].l0 + rows[r].l1;
		repeat (chars * 20 + 500) @(posedge clk);
		$display("Timeout after %0d cycles, the run did not finish", chars * 20 + 500);
		$display("Testbench failed");
		$finish;
	end

endmodule

`default_nettype wire

/* compile.f */
hdl/ice_bus_pkg.sv
hdl/frame_receiver.sv
hdl/response_buffer.sv
hdl/priority_select.sv
hdl/frame_transmitter.sv
hdl/ice_bus_controller.sv
testbench/tb_clock.sv
testbench/tb_checker.sv
testbench/tb_ice_bus_controller.sv
